/* Bender.yml */
package:
  name: eth_cfg

sources:
  # RTL
  - files:
      - hw/eth_cfg_pkg.sv
      - hw/cfg_field_reg.sv
      - hw/cfg_write_decoder.sv
      - hw/udp_port_slot.sv
      - hw/port_match_encoder.sv
      - hw/eth_cfg_top.sv

  # Verification
  - target: test
    files:
      - verification/eth_cfg_assertions.sv
      - verification/eth_cfg_tb.sv

/* hw/cfg_field_reg.sv */
`timescale 1ns/1ps

module cfg_field_reg #(
   parameter type field_t = logic [7:0]
) (
   input  logic                 cfg_clk,
   input  logic                 reset,
   input  logic                 we,
   input  eth_cfg_pkg::cfg_wr_t wr,
   output field_t               field
);
   import eth_cfg_pkg::*;

   // Byte count follows the field type
   localparam int n_bytes = $bits(field_t) / 8;

   logic [n_bytes*8-1:0] field_q;

   // ----------------------------------------------------------
   // Byte update
   // ----------------------------------------------------------

   // Position 0 lands in the top byte
   // Positions past the field match no byte
   always_ff @(posedge cfg_clk) begin
      if (reset) begin
         field_q <= '0;
      end else if (we) begin
         for (int b = 0; b < n_bytes; b++) begin
            if (wr.idx == byte_idx_t'(b)) begin
               field_q[(n_bytes-1-b)*8 +: 8] <= wr.data;
            end
         end
      end
   end

   // Hand out as the packed type
   assign field = field_t'(field_q);

endmodule

/* hw/cfg_write_decoder.sv */
`timescale 1ns/1ps

module cfg_write_decoder (
   input  logic                               cfg_clk,
   input  logic                               reset,
   input  logic                               cfg_valid,
   input  logic [4:0]                         cfg_addr,
   input  logic [7:0]                         cfg_wdata,
   output eth_cfg_pkg::cfg_wr_t               wr,
   output logic                               mac_we,
   output logic                               ip_we,
   output logic [eth_cfg_pkg::num_slots-1:0] slot_we
);
   import eth_cfg_pkg::*;

   // Input stage
   logic       valid_q;
   logic [4:0] addr_q;
   logic [7:0] wdata_q;

   // Decoded next values
   logic                 mac_we_d;
   logic                 ip_we_d;
   logic [num_slots-1:0] slot_we_d;
   byte_idx_t            idx_d;
   logic [3:0]           ip_off;

   // ----------------------------------------------------------
   // Sample the host bus
   // ----------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (reset) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= cfg_valid;
      end
      addr_q  <= cfg_addr;
      wdata_q <= cfg_wdata;
   end

   // ----------------------------------------------------------
   // Address map
   // ----------------------------------------------------------

   // Offset into the IP field
   assign ip_off = addr_q[3:0] - 4'(ip_base);

   always_comb begin
      mac_we_d  = 1'b0;
      ip_we_d   = 1'b0;
      slot_we_d = '0;
      idx_d     = '0;
      if (valid_q) begin
         if (!addr_q[4]) begin
            // Space 0, MAC then IP, rest dropped
            if (addr_q[3:0] < 4'(mac_bytes)) begin
               mac_we_d = 1'b1;
               idx_d    = byte_idx_t'(addr_q[3:0]);
            end else if (addr_q[3:0] < 4'(ip_base + ip_bytes)) begin
               ip_we_d = 1'b1;
               idx_d   = byte_idx_t'(ip_off);
            end
         end else begin
            // Space 1, two bytes per slot
            slot_we_d[addr_q[slot_w:1]] = 1'b1;
            idx_d = byte_idx_t'(addr_q[0]);
         end
      end
   end

   // Output stage
   always_ff @(posedge cfg_clk) begin
      if (reset) begin
         mac_we  <= 1'b0;
         ip_we   <= 1'b0;
         slot_we <= '0;
      end else begin
         mac_we  <= mac_we_d;
         ip_we   <= ip_we_d;
         slot_we <= slot_we_d;
      end
      wr.data <= wdata_q;
      wr.idx  <= idx_d;
   end

endmodule

/* hw/eth_cfg_pkg.sv */
package eth_cfg_pkg;

   // ----------------------------------------------------------
   // Field types
   // ----------------------------------------------------------

   // Station MAC address, byte 0 is the most significant
   typedef logic [47:0] mac_t;

   // IPv4 address, same byte order as the MAC
   typedef logic [31:0] ip_t;

   // UDP port, zero marks an unused slot
   typedef logic [15:0] udp_port_t;

   // Byte position inside a field, 0 is the MSB
   typedef logic [2:0] byte_idx_t;

   // ----------------------------------------------------------
   // Sizes
   // ----------------------------------------------------------

   // Number of UDP port slots
   localparam int num_slots = 8;

   // Width of a slot index
   localparam int slot_w = 3;

   // Byte counts of the space 0 fields
   localparam int mac_bytes = $bits(mac_t) / 8;
   localparam int ip_bytes = $bits(ip_t) / 8;

   // IP starts right after the MAC in space 0
   localparam int ip_base = mac_bytes;

   // Edges the encoder waits for the slot compares
   localparam int settle_edges = 2;

   // ----------------------------------------------------------
   // Structs
   // ----------------------------------------------------------

   // Registered write, shared by all field registers
   typedef struct packed {
      logic [7:0] data;
      byte_idx_t  idx;
   } cfg_wr_t;

   // Lookup answer
   typedef struct packed {
      logic              hit;
      logic [slot_w-1:0] slot_idx;
   } lookup_result_t;

   // Identity driven to the packet engine
   typedef struct packed {
      mac_t mac;
      ip_t  ip;
   } net_id_t;

endpackage

/* hw/eth_cfg_top.sv */
`timescale 1ns/1ps

module eth_cfg_top (
   input  logic                        cfg_clk,
   input  logic                        reset,
   input  logic                        cfg_valid,
   input  logic [4:0]                  cfg_addr,
   input  logic [7:0]                  cfg_wdata,
   input  logic                        cfg_enable_rx,
   input  logic                        lookup_req,
   input  eth_cfg_pkg::udp_port_t      lookup_port,
   output logic                        lookup_ack,
   output eth_cfg_pkg::lookup_result_t lookup_result,
   output eth_cfg_pkg::net_id_t        net_id
);
   import eth_cfg_pkg::*;

   cfg_wr_t              wr;
   logic                 mac_we;
   logic                 ip_we;
   logic [num_slots-1:0] slot_we;
   logic [num_slots-1:0] slot_match;
   mac_t                 station_mac;
   ip_t                  station_ip;

   // ----------------------------------------------------------
   // Host write path
   // ----------------------------------------------------------

   cfg_write_decoder u_write_decoder (
      .cfg_clk   (cfg_clk),
      .reset     (reset),
      .cfg_valid (cfg_valid),
      .cfg_addr  (cfg_addr),
      .cfg_wdata (cfg_wdata),
      .wr        (wr),
      .mac_we    (mac_we),
      .ip_we     (ip_we),
      .slot_we   (slot_we)
   );

   // Station identity
   cfg_field_reg #(
      .field_t (mac_t)
   ) u_mac_reg (
      .cfg_clk (cfg_clk),
      .reset   (reset),
      .we      (mac_we),
      .wr      (wr),
      .field   (station_mac)
   );

   cfg_field_reg #(
      .field_t (ip_t)
   ) u_ip_reg (
      .cfg_clk (cfg_clk),
      .reset   (reset),
      .we      (ip_we),
      .wr      (wr),
      .field   (station_ip)
   );

   assign net_id = '{mac: station_mac, ip: station_ip};

   // ----------------------------------------------------------
   // Port lookup
   // ----------------------------------------------------------

   // One slot per UDP port entry
   for (genvar i = 0; i < num_slots; i++) begin : g_slot
      udp_port_slot u_slot (
         .cfg_clk     (cfg_clk),
         .reset       (reset),
         .we          (slot_we[i]),
         .wr          (wr),
         .lookup_port (lookup_port),
         .match       (slot_match[i])
      );
   end

   port_match_encoder u_match_encoder (
      .cfg_clk       (cfg_clk),
      .reset         (reset),
      .enable_rx     (cfg_enable_rx),
      .match         (slot_match),
      .lookup_req    (lookup_req),
      .lookup_ack    (lookup_ack),
      .lookup_result (lookup_result)
   );

endmodule

/* hw/port_match_encoder.sv */
`timescale 1ns/1ps

module port_match_encoder (
   input  logic                               cfg_clk,
   input  logic                               reset,
   input  logic                               enable_rx,
   input  logic [eth_cfg_pkg::num_slots-1:0] match,
   input  logic                               lookup_req,
   output logic                               lookup_ack,
   output eth_cfg_pkg::lookup_result_t        lookup_result
);
   import eth_cfg_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_settle,
      st_acked
   } state_t;

   state_t            state_q;
   logic [1:0]        settle_cnt;
   logic              any_match;
   logic              hit;
   logic [slot_w-1:0] first_idx;

   // ----------------------------------------------------------
   // Priority encoder
   // ----------------------------------------------------------

   // Walk down so the lowest slot wins
   always_comb begin
      first_idx = '0;
      for (int i = num_slots - 1; i >= 0; i--) begin
         if (match[i]) begin
            first_idx = slot_w'(i);
         end
      end
   end

   assign any_match = |match;

   // Disabled receive forces a miss
   assign hit = any_match && enable_rx;

   // ----------------------------------------------------------
   // Handshake FSM
   // ----------------------------------------------------------

   always_ff @(posedge cfg_clk) begin
      if (reset) begin
         state_q       <= st_idle;
         settle_cnt    <= '0;
         lookup_result <= '0;
      end else begin
         case (state_q)
            st_idle: begin
               // First edge with req high
               if (lookup_req) begin
                  state_q    <= st_settle;
                  settle_cnt <= '0;
               end
            end
            st_settle: begin
               if (!lookup_req) begin
                  state_q <= st_idle;
               end else if (settle_cnt == 2'(settle_edges - 1)) begin
                  // Matches now follow the held port
                  state_q                <= st_acked;
                  lookup_result.hit      <= hit;
                  lookup_result.slot_idx <= hit ? first_idx : '0;
               end else begin
                  settle_cnt <= settle_cnt + 2'd1;
               end
            end
            st_acked: begin
               // Result held until req drops
               if (!lookup_req) begin
                  state_q <= st_idle;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   assign lookup_ack = (state_q == st_acked);

endmodule

/* hw/udp_port_slot.sv */
`timescale 1ns/1ps

module udp_port_slot (
   input  logic                   cfg_clk,
   input  logic                   reset,
   input  logic                   we,
   input  eth_cfg_pkg::cfg_wr_t   wr,
   input  eth_cfg_pkg::udp_port_t lookup_port,
   output logic                   match
);
   import eth_cfg_pkg::*;

   // Stored port of this slot
   udp_port_t port;
   logic      used;
   logic      equal;

   // ----------------------------------------------------------
   // Port storage
   // ----------------------------------------------------------

   // High byte at position 0
   cfg_field_reg #(
      .field_t (udp_port_t)
   ) u_port_reg (
      .cfg_clk (cfg_clk),
      .reset   (reset),
      .we      (we),
      .wr      (wr),
      .field   (port)
   );

   // ----------------------------------------------------------
   // Compare
   // ----------------------------------------------------------

   // Zero port means slot not in use
   assign used  = (port != '0);
   assign equal = (port == lookup_port);

   // Registered every cycle
   always_ff @(posedge cfg_clk) begin
      if (reset) begin
         match <= 1'b0;
      end else begin
         match <= used && equal;
      end
   end

endmodule

/* list.f */
hw/eth_cfg_pkg.sv
hw/cfg_field_reg.sv
hw/cfg_write_decoder.sv
hw/udp_port_slot.sv
hw/port_match_encoder.sv
hw/eth_cfg_top.sv
verification/eth_cfg_assertions.sv
verification/eth_cfg_tb.sv

/* verification/eth_cfg_assertions.sv */
`timescale 1ns/1ps

module eth_cfg_assertions (
   input logic                        cfg_clk,
   input logic                        reset,
   input logic                        lookup_req,
   input logic                        lookup_ack,
   input eth_cfg_pkg::lookup_result_t lookup_result
);

   // ----------------------------------------------------------
   // Four-phase handshake rules
   // ----------------------------------------------------------

   // Ack only answers a pending request
   ack_needs_req: assert property (
      @(posedge cfg_clk) disable iff (reset)
      $rose(lookup_ack) |-> $past(lookup_req)
   ) else $error("lookup_ack rose without lookup_req");

   // Answer frozen while acked
   result_held: assert property (
      @(posedge cfg_clk) disable iff (reset)
      lookup_ack && $past(lookup_ack) |-> $stable(lookup_result)
   ) else $error("lookup_result changed while lookup_ack high");

   // Release follows req quickly
   ack_release: assert property (
      @(posedge cfg_clk) disable iff (reset)
      $fell(lookup_req) |-> ##[0:2] !lookup_ack
   ) else $error("lookup_ack still high two cycles after lookup_req fell");

endmodule

/* verification/eth_cfg_tb.sv */
`timescale 1ns/1ps

module eth_cfg_tb;
   import eth_cfg_pkg::*;

   // Cycles allowed for each ack edge
   localparam int ack_timeout = 16;

   logic           cfg_clk;
   logic           reset;
   logic           cfg_valid;
   logic [4:0]     cfg_addr;
   logic [7:0]     cfg_wdata;
   logic           cfg_enable_rx;
   logic           lookup_req;
   udp_port_t      lookup_port;
   logic           lookup_ack;
   lookup_result_t lookup_result;
   net_id_t        net_id;

   // Reference model of the address map
   logic [7:0] mac_m [6];
   logic [7:0] ip_m [4];
   udp_port_t  port_m [num_slots];

   integer seed = 32'h871f_91eb;
   int     errors = 0;
   int     test_count = 0;
   int     errors_at_start = 0;
   int     hold;
   udp_port_t p;

   eth_cfg_top u_eth_cfg_top (
      .cfg_clk       (cfg_clk),
      .reset         (reset),
      .cfg_valid     (cfg_valid),
      .cfg_addr      (cfg_addr),
      .cfg_wdata     (cfg_wdata),
      .cfg_enable_rx (cfg_enable_rx),
      .lookup_req    (lookup_req),
      .lookup_port   (lookup_port),
      .lookup_ack    (lookup_ack),
      .lookup_result (lookup_result),
      .net_id        (net_id)
   );

   bind port_match_encoder eth_cfg_assertions u_handshake_checks (
      .cfg_clk       (cfg_clk),
      .reset         (reset),
      .lookup_req    (lookup_req),
      .lookup_ack    (lookup_ack),
      .lookup_result (lookup_result)
   );

   // 100 ns clock
   initial cfg_clk = 1'b0;
   always #50 cfg_clk = ~cfg_clk;

   // ----------------------------------------------------------
   // Model
   // ----------------------------------------------------------

   function automatic void model_write(input logic [4:0] addr, input logic [7:0] data);
      if (!addr[4]) begin
         // MAC 0..5, IP 6..9, rest ignored
         if (addr[3:0] < 4'd6) mac_m[addr[3:0]] = data;
         else if (addr[3:0] < 4'd10) ip_m[addr[3:0] - 4'd6] = data;
      end else if (!addr[0]) begin
         port_m[addr[3:1]][15:8] = data;
      end else begin
         port_m[addr[3:1]][7:0] = data;
      end
   endfunction

   function automatic net_id_t model_net_id();
      net_id_t id;
      for (int b = 0; b < 6; b++) id.mac[(5-b)*8 +: 8] = mac_m[b];
      for (int b = 0; b < 4; b++) id.ip[(3-b)*8 +: 8] = ip_m[b];
      return id;
   endfunction

   // Lowest nonzero slot equal to the port
   function automatic lookup_result_t model_lookup(input udp_port_t port, input logic en);
      lookup_result_t r;
      r = '0;
      for (int i = num_slots - 1; i >= 0; i--) begin
         if (port_m[i] != '0 && port_m[i] == port) r.slot_idx = slot_w'(i);
      end
      r.hit = en && (port_m[r.slot_idx] == port) && (port != '0);
      if (!r.hit) r.slot_idx = '0;
      return r;
   endfunction

   // ----------------------------------------------------------
   // Bus tasks
   // ----------------------------------------------------------

   task automatic write_byte(input logic [4:0] addr, input logic [7:0] data);
      @(posedge cfg_clk);
      cfg_valid <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= data;
      model_write(addr, data);
   endtask

   // Write lands two edges after the sampling edge
   task automatic settle_writes();
      @(posedge cfg_clk);
      cfg_valid <= 1'b0;
      repeat (3) @(posedge cfg_clk);
   endtask

   task automatic check_net_id();
      net_id_t exp;
      exp = model_net_id();
      @(negedge cfg_clk);
      assert (net_id == exp) else begin
         $display("[ERROR] net_id got %h expected %h", net_id, exp);
         errors++;
      end
   endtask

   // Full four-phase lookup, req held for hold cycles after ack
   task automatic check_lookup(input udp_port_t port, input int hold_cycles);
      lookup_result_t exp;
      lookup_result_t got;
      int waited;
      @(posedge cfg_clk);
      // Enable as settled by earlier edges
      exp = model_lookup(port, cfg_enable_rx);
      lookup_req  <= 1'b1;
      lookup_port <= port;
      waited = 0;
      do begin
         @(negedge cfg_clk);
         waited++;
      end while (!lookup_ack && waited < ack_timeout);
      assert (lookup_ack) else begin
         $display("Timeout, lookup_ack never rose for port %h", port);
         errors++;
      end
      got = lookup_result;
      assert (got == exp) else begin
         $display("[ERROR] lookup_result port %h got %h expected %h", port, got, exp);
         errors++;
      end
      // Back-pressure
      for (int i = 0; i < hold_cycles; i++) begin
         @(negedge cfg_clk);
         assert (lookup_ack && lookup_result == exp) else begin
            $display("[ERROR] lookup_ack %h lookup_result %h expected held %h",
                     lookup_ack, lookup_result, exp);
            errors++;
         end
      end
      @(posedge cfg_clk);
      lookup_req <= 1'b0;
      waited = 0;
      do begin
         @(negedge cfg_clk);
         waited++;
      end while (lookup_ack && waited < ack_timeout);
      assert (!lookup_ack) else begin
         $display("Timeout, lookup_ack never fell for port %h", port);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("test %0d %s finished with %0d errors", test_count, name,
               errors - errors_at_start);
      errors_at_start = errors;
   endtask

   // ----------------------------------------------------------
   // Sequence
   // ----------------------------------------------------------

   initial begin
      reset         = 1'b1;
      cfg_valid     = 1'b0;
      cfg_addr      = '0;
      cfg_wdata     = '0;
      cfg_enable_rx = 1'b1;
      lookup_req    = 1'b0;
      lookup_port   = '0;
      foreach (mac_m[i]) mac_m[i] = '0;
      foreach (ip_m[i]) ip_m[i] = '0;
      foreach (port_m[i]) port_m[i] = '0;
      repeat (5) @(posedge cfg_clk);
      reset <= 1'b0;

      // Reset state
      check_net_id();
      check_lookup(udp_port_t'($random(seed)), 0);
      end_test("reset");

      // Random space 0 writes, then the ignored range
      for (int i = 0; i < 24; i++) write_byte({1'b0, 4'($random(seed))}, 8'($random(seed)));
      settle_writes();
      check_net_id();
      for (int a = 10; a < 16; a++) write_byte(5'(a), 8'($random(seed)));
      settle_writes();
      check_net_id();
      end_test("mac_ip");

      // Fill all slots, nonzero ports
      for (int s = 0; s < num_slots; s++) begin
         p = udp_port_t'($random(seed));
         if (p == '0) p = 16'h0001;
         write_byte(5'(16 + 2*s), p[15:8]);
         write_byte(5'(17 + 2*s), p[7:0]);
      end
      settle_writes();
      for (int s = 0; s < num_slots; s++) check_lookup(port_m[s], 0);
      for (int i = 0; i < 8; i++) check_lookup(udp_port_t'($random(seed)), 0);
      end_test("slots");

      // Duplicate port, lowest slot wins
      p = udp_port_t'($random(seed)) | 16'h0100;
      for (int s = 6; s >= 2; s -= 2) begin
         write_byte(5'(16 + 2*s), p[15:8]);
         write_byte(5'(17 + 2*s), p[7:0]);
      end
      settle_writes();
      check_lookup(p, 0);
      write_byte(5'(20), 8'h00);
      write_byte(5'(21), 8'h00);
      settle_writes();
      check_lookup(p, 0);
      end_test("priority");

      // Receive disabled then restored
      @(posedge cfg_clk);
      cfg_enable_rx <= 1'b0;
      for (int s = 0; s < num_slots; s++) check_lookup(port_m[s], 0);
      @(posedge cfg_clk);
      cfg_enable_rx <= 1'b1;
      for (int s = 0; s < num_slots; s++) check_lookup(port_m[s], 0);
      end_test("enable_rx");

      // Requester holds req after ack
      for (int i = 0; i < 8; i++) begin
         hold = 1 + ({$random(seed)} % 8);
         check_lookup(port_m[{$random(seed)} % num_slots], hold);
      end
      end_test("backpressure");

      $display("tests run %0d, errors %0d", test_count, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
